// ==== src/vec_pkg.sv ====
/* Shared types for the lane-based vector unit.
   Element width and register count are fixed here; lane count and rows per lane
   come from the top level and must fit MaxRowWidth. */

package vec_pkg;

  ////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////

  // Bits per vector element
  localparam int unsigned ElemWidth = 16;

  // Architectural vector registers
  localparam int unsigned NrVRegs = 8;

  // Row index width, so at most 16 elements per lane
  localparam int unsigned MaxRowWidth = 4;

  // Structural limits of the design, not checked in hardware:
  // NrLanes must be a power of two, since the cross-lane adder tree is balanced.
  // NrLanes * ElemsPerLane must be non-zero, so at least one lane and one row.
  // ElemsPerLane must not exceed 2**MaxRowWidth.

  ////////////////////////////////////////
  // Basic types
  ////////////////////////////////////////

  typedef logic [ElemWidth-1:0] elem_t;

  typedef logic [$clog2(NrVRegs)-1:0] vreg_idx_t;

  // Kept subset of the integer vector operations
  typedef enum logic [2:0] {
    VMV_VX  = 3'd0,
    VID     = 3'd1,
    VADD_VV = 3'd2,
    VSUB_VV = 3'd3,
    VAND_VV = 3'd4,
    VXOR_VV = 3'd5,
    VADD_VX = 3'd6,
    VREDSUM = 3'd7
  } vec_op_e;

  ////////////////////////////////////////
  // Structs
  ////////////////////////////////////////

  // One instruction as strobed in from outside
  typedef struct packed {
    vec_op_e   op;
    vreg_idx_t vd;
    vreg_idx_t vs1;
    vreg_idx_t vs2;
    elem_t     scalar;
  } vec_insn_t;

  // Element-group request, broadcast to all lanes
  typedef struct packed {
    vec_op_e                op;
    vreg_idx_t              vd;
    vreg_idx_t              vs1;
    vreg_idx_t              vs2;
    elem_t                  scalar;
    logic [MaxRowWidth-1:0] row;
    // Marks the final row of the instruction
    logic                   last;
  } lane_req_t;

endpackage

// ==== src/vec_sequencer.sv ====
/* Accepts one instruction per strobe; strobes during busy are dropped.
   Steps rows 0..ElemsPerLane-1 out to the lanes, one per cycle. */

module vec_sequencer #(
  parameter int unsigned ElemsPerLane = 4
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  // Instruction input
  input  logic               insn_valid_i,
  input  vec_pkg::vec_insn_t insn_i,
  output logic               busy_o,
  // Broadcast to the lanes
  output logic               req_valid_o,
  output vec_pkg::lane_req_t req_o
);

  // Issue, two lane stages and the reduction register
  localparam int unsigned BusyCycles = ElemsPerLane + 3;
  localparam int unsigned CntWidth   = $clog2(BusyCycles + 1);
  localparam logic [vec_pkg::MaxRowWidth-1:0] LastRow =
    vec_pkg::MaxRowWidth'(ElemsPerLane - 1);

  vec_pkg::vec_insn_t                   insn_q;
  logic [vec_pkg::MaxRowWidth-1:0]      row_q;
  logic                                 issuing_q;
  logic [CntWidth-1:0]                  busy_cnt_q;
  logic                                 accept;
  logic                                 last_row;

  assign busy_o   = (busy_cnt_q != '0);
  assign accept   = insn_valid_i && !busy_o;
  assign last_row = (row_q == LastRow);

  ////////////////////////////////////////
  // Busy window
  ////////////////////////////////////////

  // Covers issue plus drain of lanes and reduction
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_cnt_q <= '0;
    end else if (accept) begin
      busy_cnt_q <= CntWidth'(BusyCycles);
    end else if (busy_o) begin
      busy_cnt_q <= busy_cnt_q - 1'b1;
    end
  end

  ////////////////////////////////////////
  // Row stepping
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      issuing_q <= 1'b0;
      row_q     <= '0;
    end else if (accept) begin
      issuing_q <= 1'b1;
      row_q     <= '0;
    end else if (issuing_q) begin
      if (last_row) begin
        issuing_q <= 1'b0;
      end else begin
        row_q <= row_q + 1'b1;
      end
    end
  end

  // Instruction payload
  always_ff @(posedge clk_i) begin
    if (accept) begin
      insn_q <= insn_i;
    end
  end

  // Request is the latched instruction tagged with the current row
  always_comb begin
    req_o.op     = insn_q.op;
    req_o.vd     = insn_q.vd;
    req_o.vs1    = insn_q.vs1;
    req_o.vs2    = insn_q.vs2;
    req_o.scalar = insn_q.scalar;
    req_o.row    = row_q;
    req_o.last   = last_row;
  end

  assign req_valid_o = issuing_q;

endmodule

// ==== src/vec_vrf.sv ====
/* One lane's slice of the register file, NrVRegs x ElemsPerLane elements.
   Reads are registered; a read colliding with a write returns the old value. */

module vec_vrf #(
  parameter  int unsigned ElemsPerLane = 4,
  localparam int unsigned AddrWidth    = $bits(vec_pkg::vreg_idx_t) + vec_pkg::MaxRowWidth
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  // Read ports, address is {register, row}
  input  logic [AddrWidth-1:0] raddr_a_i,
  input  logic [AddrWidth-1:0] raddr_b_i,
  output vec_pkg::elem_t       rdata_a_o,
  output vec_pkg::elem_t       rdata_b_o,
  // Write port
  input  logic                 we_i,
  input  logic [AddrWidth-1:0] waddr_i,
  input  vec_pkg::elem_t       wdata_i
);

  localparam int unsigned Depth = vec_pkg::NrVRegs * ElemsPerLane;

  vec_pkg::elem_t mem_q [Depth];

  // Flatten {register, row} to a storage index
  function automatic int unsigned elem_index(input logic [AddrWidth-1:0] addr);
    return ElemsPerLane * addr[AddrWidth-1:vec_pkg::MaxRowWidth]
           + addr[vec_pkg::MaxRowWidth-1:0];
  endfunction

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int unsigned i = 0; i < Depth; i++) begin
        mem_q[i] <= '0;
      end
      rdata_a_o <= '0;
      rdata_b_o <= '0;
    end else begin
      if (we_i) begin
        mem_q[elem_index(waddr_i)] <= wdata_i;
      end
      rdata_a_o <= mem_q[elem_index(raddr_a_i)];
      rdata_b_o <= mem_q[elem_index(raddr_b_i)];
    end
  end

endmodule

// ==== src/vec_lane.sv ====
/* Two-stage lane: read stage, then ALU and write-back or reduction output.
   No stalls; up to two element groups in flight. */

module vec_lane #(
  parameter int unsigned NrLanes      = 4,
  parameter int unsigned ElemsPerLane = 4,
  parameter int unsigned LaneId       = 0
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  // From the sequencer
  input  logic               req_valid_i,
  input  vec_pkg::lane_req_t req_i,
  // To the reduction unit
  output logic               red_valid_o,
  output logic               red_last_o,
  output vec_pkg::elem_t     red_value_o
);

  vec_pkg::lane_req_t s1_req_q;
  logic               s1_valid_q;
  vec_pkg::elem_t     opa;
  vec_pkg::elem_t     opb;
  vec_pkg::elem_t     elem_idx;
  vec_pkg::elem_t     alu_res;
  logic               is_red;
  logic               wr_en;

  ////////////////////////////////////////
  // Stage one: request and operand read
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      s1_valid_q <= 1'b0;
    end else begin
      s1_valid_q <= req_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    s1_req_q <= req_i;
  end

  vec_vrf #(
    .ElemsPerLane(ElemsPerLane)
  ) i_vrf (
    .clk_i    (clk_i                        ),
    .rst_n_i  (rst_n_i                      ),
    .raddr_a_i({req_i.vs1, req_i.row}      ),
    .raddr_b_i({req_i.vs2, req_i.row}      ),
    .rdata_a_o(opa                          ),
    .rdata_b_o(opb                          ),
    .we_i     (wr_en                        ),
    .waddr_i  ({s1_req_q.vd, s1_req_q.row}  ),
    .wdata_i  (alu_res                      )
  );

  ////////////////////////////////////////
  // Stage two: ALU and write-back
  ////////////////////////////////////////

  // Global element index of this lane's element in the current row
  assign elem_idx = vec_pkg::elem_t'(s1_req_q.row) * vec_pkg::elem_t'(NrLanes)
                    + vec_pkg::elem_t'(LaneId);

  always_comb begin
    unique case (s1_req_q.op)
      vec_pkg::VMV_VX:  alu_res = s1_req_q.scalar;
      vec_pkg::VID:     alu_res = elem_idx;
      vec_pkg::VADD_VV: alu_res = opa + opb;
      vec_pkg::VSUB_VV: alu_res = opa - opb;
      vec_pkg::VAND_VV: alu_res = opa & opb;
      vec_pkg::VXOR_VV: alu_res = opa ^ opb;
      vec_pkg::VADD_VX: alu_res = opa + s1_req_q.scalar;
      default:          alu_res = '0;
    endcase
  end

  assign is_red = (s1_req_q.op == vec_pkg::VREDSUM);
  assign wr_en  = s1_valid_q && !is_red;

  // Reduction operand goes out instead of being written
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      red_valid_o <= 1'b0;
      red_last_o  <= 1'b0;
    end else begin
      red_valid_o <= s1_valid_q && is_red;
      red_last_o  <= s1_valid_q && is_red && s1_req_q.last;
    end
  end

  always_ff @(posedge clk_i) begin
    red_value_o <= opa;
  end

endmodule

// ==== src/vec_reduction.sv ====
/* Cross-lane sum with an accumulator over rows.
   The adder tree assumes NrLanes is a power of two. */

module vec_reduction #(
  parameter int unsigned NrLanes = 4
) (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  // Lane outputs, lanes move in lockstep
  input  logic                             red_valid_i,
  input  logic                             red_last_i,
  input  vec_pkg::elem_t [NrLanes-1:0]     red_value_i,
  // Scalar result
  output logic                             resp_valid_o,
  output vec_pkg::elem_t                   resp_o
);

  // Heap-ordered tree, leaves at NrLanes..2*NrLanes-1, root at 1
  vec_pkg::elem_t node [1:2*NrLanes-1];
  vec_pkg::elem_t acc_q;
  vec_pkg::elem_t acc_base;
  vec_pkg::elem_t acc_next;
  logic           first_q;

  ////////////////////////////////////////
  // Adder tree
  ////////////////////////////////////////

  for (genvar i = 0; i < NrLanes; i++) begin : gen_leaves
    assign node[NrLanes+i] = red_value_i[i];
  end

  for (genvar i = 1; i < NrLanes; i++) begin : gen_nodes
    assign node[i] = node[2*i] + node[2*i+1];
  end

  ////////////////////////////////////////
  // Accumulator
  ////////////////////////////////////////

  // First group of an instruction starts from zero
  assign acc_base = first_q ? '0 : acc_q;
  assign acc_next = acc_base + node[1];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      acc_q        <= '0;
      first_q      <= 1'b1;
      resp_valid_o <= 1'b0;
      resp_o       <= '0;
    end else begin
      resp_valid_o <= 1'b0;
      if (red_valid_i) begin
        if (red_last_i) begin
          resp_o       <= acc_next;
          resp_valid_o <= 1'b1;
          first_q      <= 1'b1;
        end else begin
          acc_q   <= acc_next;
          first_q <= 1'b0;
        end
      end
    end
  end

endmodule

// ==== src/vector_core.sv ====
/* Lane-based vector unit, one instruction at a time, no back-pressure.
   NrLanes must be a power of two and ElemsPerLane at most 16.
   Strobes while busy_o is high are dropped. */

module vector_core #(
  parameter int unsigned NrLanes      = 4,
  parameter int unsigned ElemsPerLane = 4
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  // Instruction strobe
  input  logic               insn_valid_i,
  input  vec_pkg::vec_insn_t insn_i,
  output logic               busy_o,
  // Reduction response
  output logic               resp_valid_o,
  output vec_pkg::elem_t     resp_o
);

  ////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////

  logic               req_valid;
  vec_pkg::lane_req_t req;

  vec_sequencer #(
    .ElemsPerLane(ElemsPerLane)
  ) i_sequencer (
    .clk_i       (clk_i       ),
    .rst_n_i     (rst_n_i     ),
    .insn_valid_i(insn_valid_i),
    .insn_i      (insn_i      ),
    .busy_o      (busy_o      ),
    .req_valid_o (req_valid   ),
    .req_o       (req         )
  );

  ////////////////////////////////////////
  // Lanes
  ////////////////////////////////////////

  logic           [NrLanes-1:0] red_valid;
  logic           [NrLanes-1:0] red_last;
  vec_pkg::elem_t [NrLanes-1:0] red_value;

  for (genvar lane = 0; lane < NrLanes; lane++) begin : gen_lanes
    vec_lane #(
      .NrLanes     (NrLanes     ),
      .ElemsPerLane(ElemsPerLane),
      .LaneId      (lane        )
    ) i_lane (
      .clk_i      (clk_i          ),
      .rst_n_i    (rst_n_i        ),
      .req_valid_i(req_valid      ),
      .req_i      (req            ),
      .red_valid_o(red_valid[lane]),
      .red_last_o (red_last[lane] ),
      .red_value_o(red_value[lane])
    );
  end : gen_lanes

  ////////////////////////////////////////
  // Reduction
  ////////////////////////////////////////

  // Lanes run in lockstep, lane 0 carries the group flags
  vec_reduction #(
    .NrLanes(NrLanes)
  ) i_reduction (
    .clk_i       (clk_i       ),
    .rst_n_i     (rst_n_i     ),
    .red_valid_i (red_valid[0]),
    .red_last_i  (red_last[0] ),
    .red_value_i (red_value   ),
    .resp_valid_o(resp_valid_o),
    .resp_o      (resp_o      )
  );

endmodule

// ==== bench/tb_clock_gen.sv ====
/* Free-running clock and active-low reset for the testbench.
   Reset is released on a falling edge after ResetCycles rising edges. */

module tb_clock_gen #(
  parameter int unsigned Period      = 10,
  parameter int unsigned ResetCycles = 10
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #(Period / 2) clk_o = ~clk_o;
    end
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

// ==== bench/tb_vector_core.sv ====
/* Self-checking testbench for vector_core at the default lane geometry.
   Expected sums come from a model register file; the first mismatch stops the run. */

module tb_vector_core;

  localparam int unsigned NrLanes      = 4;
  localparam int unsigned ElemsPerLane = 4;
  localparam int unsigned VL           = NrLanes * ElemsPerLane;
  localparam int unsigned ResetCycles  = 10;
  localparam int unsigned Seed         = 10171;
  // Instructions issued by all tests
  localparam int unsigned NumInsns     = 124;
  localparam int unsigned MaxCycles    = 20 * (ElemsPerLane + 5) * NumInsns + ResetCycles;

  logic               clk;
  logic               rst_n;
  logic               insn_valid;
  vec_pkg::vec_insn_t insn;
  logic               busy;
  logic               resp_valid;
  vec_pkg::elem_t     resp;

  vec_pkg::elem_t     model_vrf [vec_pkg::NrVRegs][VL];
  vec_pkg::elem_t     expected_q [$];
  vec_pkg::elem_t     last_resp;
  int unsigned        cycle_count;

  tb_clock_gen #(
    .Period     (10         ),
    .ResetCycles(ResetCycles)
  ) i_clock_gen (
    .clk_o  (clk  ),
    .rst_n_o(rst_n)
  );

  vector_core #(
    .NrLanes     (NrLanes     ),
    .ElemsPerLane(ElemsPerLane)
  ) dut_i (
    .clk_i       (clk       ),
    .rst_n_i     (rst_n     ),
    .insn_valid_i(insn_valid),
    .insn_i      (insn      ),
    .busy_o      (busy      ),
    .resp_valid_o(resp_valid),
    .resp_o      (resp      )
  );

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // Element idx of vd for one element-wise instruction
  function automatic vec_pkg::elem_t ref_elem(input vec_pkg::vec_insn_t x,
                                              input int unsigned idx,
                                              input vec_pkg::elem_t a,
                                              input vec_pkg::elem_t b);
    case (x.op)
      vec_pkg::VMV_VX:  return x.scalar;
      vec_pkg::VID:     return vec_pkg::elem_t'(idx);
      vec_pkg::VADD_VV: return a + b;
      vec_pkg::VSUB_VV: return a - b;
      vec_pkg::VAND_VV: return a & b;
      vec_pkg::VXOR_VV: return a ^ b;
      vec_pkg::VADD_VX: return a + x.scalar;
      default:          return '0;
    endcase
  endfunction

  // Sum of all elements, wrapping at the element width
  function automatic vec_pkg::elem_t ref_redsum(input vec_pkg::vreg_idx_t vs);
    vec_pkg::elem_t sum;
    sum = '0;
    for (int unsigned i = 0; i < VL; i++) begin
      sum += model_vrf[vs][i];
    end
    return sum;
  endfunction

  // All sources are read before vd is overwritten
  task automatic update_model(input vec_pkg::vec_insn_t x);
    vec_pkg::elem_t result [VL];
    for (int unsigned i = 0; i < VL; i++) begin
      result[i] = ref_elem(x, i, model_vrf[x.vs1][i], model_vrf[x.vs2][i]);
    end
    for (int unsigned i = 0; i < VL; i++) begin
      model_vrf[x.vd][i] = result[i];
    end
  endtask

  ////////////////////////////////////////
  // Checking
  ////////////////////////////////////////

  task automatic abort_run();
    $display("Errors found");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input int actual, input int expected, input string what);
    if (actual != expected) begin
      $display("error at %0t: %s is %0d, expected %0d", $time, what, actual, expected);
      abort_run();
    end
  endtask

  // Every response must match the oldest outstanding reduction
  always @(negedge clk) begin : compare_resp
    vec_pkg::elem_t expected;
    if (rst_n && resp_valid) begin
      if (expected_q.size() == 0) begin
        $display("resp_valid_o pulsed at %0t with no reduction outstanding", $time);
        abort_run();
      end else begin
        expected  = expected_q.pop_front();
        last_resp = resp;
        check_value(resp, expected, "VREDSUM result");
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= MaxCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", MaxCycles);
      abort_run();
    end
  end

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////

  function automatic vec_pkg::vec_insn_t make_insn(input vec_pkg::vec_op_e op,
                                                   input int unsigned vd,
                                                   input int unsigned vs1,
                                                   input int unsigned vs2,
                                                   input vec_pkg::elem_t scalar);
    vec_pkg::vec_insn_t r;
    r.op     = op;
    r.vd     = vec_pkg::vreg_idx_t'(vd);
    r.vs1    = vec_pkg::vreg_idx_t'(vs1);
    r.vs2    = vec_pkg::vreg_idx_t'(vs2);
    r.scalar = scalar;
    return r;
  endfunction

  function automatic vec_pkg::vec_insn_t redsum_insn(input int unsigned vs);
    return make_insn(vec_pkg::VREDSUM, 0, vs, 0, '0);
  endfunction

  // Any non-reduction operation over random registers
  function automatic vec_pkg::vec_insn_t random_elem_insn();
    vec_pkg::vec_op_e op;
    case ($urandom_range(0, 6))
      0:       op = vec_pkg::VMV_VX;
      1:       op = vec_pkg::VID;
      2:       op = vec_pkg::VADD_VV;
      3:       op = vec_pkg::VSUB_VV;
      4:       op = vec_pkg::VAND_VV;
      5:       op = vec_pkg::VXOR_VV;
      default: op = vec_pkg::VADD_VX;
    endcase
    return make_insn(op, $urandom_range(0, vec_pkg::NrVRegs - 1),
                     $urandom_range(0, vec_pkg::NrVRegs - 1),
                     $urandom_range(0, vec_pkg::NrVRegs - 1), vec_pkg::elem_t'($urandom()));
  endfunction

  // Strobe x, then watch the busy window; extra is strobed at busy cycle inject_at
  task automatic issue_insn(input vec_pkg::vec_insn_t x, input int inject_at,
                            input vec_pkg::vec_insn_t extra);
    int busy_cycles;
    int resp_at;
    while (busy) @(negedge clk);
    if (x.op == vec_pkg::VREDSUM) begin
      expected_q.push_back(ref_redsum(x.vs1));
    end
    insn       = x;
    insn_valid = 1'b1;
    @(negedge clk);
    insn_valid  = 1'b0;
    busy_cycles = 0;
    resp_at     = -1;
    while (busy) begin
      if (resp_valid) begin
        resp_at = busy_cycles;
      end
      if (busy_cycles == inject_at) begin
        insn       = extra;
        insn_valid = 1'b1;
      end else begin
        insn_valid = 1'b0;
      end
      busy_cycles++;
      @(negedge clk);
    end
    insn_valid = 1'b0;
    check_value(busy_cycles, ElemsPerLane + 3, "busy_o length");
    if (x.op == vec_pkg::VREDSUM) begin
      if (expected_q.size() != 0) begin
        $display("VREDSUM issued before %0t finished without a response", $time);
        abort_run();
      end else begin
        check_value(resp_at, ElemsPerLane + 2, "resp_valid_o position in busy window");
      end
    end else begin
      update_model(x);
    end
  endtask

  task automatic run_insn(input vec_pkg::vec_insn_t x);
    issue_insn(x, -1, '0);
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  initial begin
    vec_pkg::vec_insn_t base;
    vec_pkg::vec_insn_t dropped;
    void'($urandom(Seed));
    insn_valid  = 1'b0;
    insn        = '0;
    cycle_count = 0;
    for (int r = 0; r < vec_pkg::NrVRegs; r++) begin
      for (int i = 0; i < VL; i++) begin
        model_vrf[r][i] = '0;
      end
    end
    @(posedge rst_n);

    // Idle outputs and cleared register file
    repeat (5) begin
      @(negedge clk);
      check_value(busy, 0, "busy_o after reset");
      check_value(resp_valid, 0, "resp_valid_o after reset");
      check_value(resp, 0, "resp_o after reset");
    end
    for (int r = 0; r < vec_pkg::NrVRegs; r++) begin
      run_insn(redsum_insn(r));
    end

    // Index vector sums to VL(VL-1)/2
    run_insn(make_insn(vec_pkg::VID, 1, 0, 0, '0));
    run_insn(redsum_insn(1));
    check_value(last_resp, (VL * (VL - 1) / 2) % (1 << vec_pkg::ElemWidth),
                "VREDSUM of VID");
    run_insn(make_insn(vec_pkg::VID, 7, 0, 0, '0));
    run_insn(redsum_insn(7));

    // Splat and scalar add
    for (int k = 0; k < 4; k++) begin
      run_insn(make_insn(vec_pkg::VMV_VX, 2, 0, 0, vec_pkg::elem_t'($urandom())));
      run_insn(make_insn(vec_pkg::VADD_VX, 3, 2, 0, vec_pkg::elem_t'($urandom())));
      run_insn(redsum_insn(2));
      run_insn(redsum_insn(3));
    end

    // Random element-wise sequences
    for (int r = 0; r < vec_pkg::NrVRegs; r++) begin
      run_insn(make_insn(vec_pkg::VMV_VX, r, 0, 0, vec_pkg::elem_t'($urandom())));
    end
    for (int k = 0; k < 40; k++) begin
      base = random_elem_insn();
      run_insn(base);
      run_insn(redsum_insn(base.vd));
    end

    // Strobes while busy, early and on the last busy cycle
    for (int k = 0; k < 4; k++) begin
      dropped = make_insn(vec_pkg::VMV_VX, $urandom_range(0, vec_pkg::NrVRegs - 1), 0, 0,
                          vec_pkg::elem_t'($urandom()));
      base    = (k % 2 == 0) ? random_elem_insn()
                             : redsum_insn($urandom_range(0, vec_pkg::NrVRegs - 1));
      issue_insn(base, (k < 2) ? 1 : int'(ElemsPerLane + 2), dropped);
      run_insn(redsum_insn(dropped.vd));
    end

    repeat (3) @(negedge clk);
    $display("No errors");
    $finish;
  end

endmodule

// ==== vector_core.f ====
src/vec_pkg.sv
src/vec_sequencer.sv
src/vec_vrf.sv
src/vec_lane.sv
src/vec_reduction.sv
src/vector_core.sv
bench/tb_clock_gen.sv
bench/tb_vector_core.sv
